/* files.f */
hdl/fx2_pkg.sv
hdl/tagger_pkg.sv
hdl/fx2_bidir.sv
hdl/cmd_engine.sv
hdl/pulse_queue.sv
hdl/tagger_top.sv
tests/tb_tagger_top.sv

/* hdl/cmd_engine.sv */
`timescale 1ns/1ps

module cmd_engine (
	input  logic                   fifo_clk,
	input  logic                   rst_n,
	// Host bytes from the link
	input  fx2_pkg::fx2_byte_t     cmd,
	input  logic                   cmd_wr,
	// One strobe per lost event
	input  logic                   drop_pulse,
	// Reply stream
	output fx2_pkg::fx2_byte_t     reply,
	output logic                   reply_rdy,
	output logic                   reply_end,
	input  logic                   reply_ack,
	// Channel enables for the pulse front end
	output tagger_pkg::chan_mask_t chan_mask
);
	import fx2_pkg::*;
	import tagger_pkg::*;

	opcode_t     opcode;
	chan_mask_t  arg;            // Argument nibble
	drop_count_t drops;
	reply_cnt_t  reply_left;     // Bytes still to send
	fx2_byte_t   reply_next;     // Second byte of a two-byte reply
	logic        do_set_mask;
	logic        do_get_mask;
	logic        do_get_drops;
	logic        do_clr_drops;

	// ************************************************************
	// Decode
	// ************************************************************

	assign opcode = opcode_t'(cmd[7:4]);
	assign arg    = chan_mask_t'(cmd[3:0]);

	assign do_set_mask  = cmd_wr && (opcode == OP_SET_MASK);
	assign do_clr_drops = cmd_wr && (opcode == OP_CLR_DROPS);
	// Reply requests are dropped while a reply is pending
	assign do_get_mask  = cmd_wr && (opcode == OP_GET_MASK) && !reply_rdy;
	assign do_get_drops = cmd_wr && (opcode == OP_GET_DROPS) && !reply_rdy;

	// ************************************************************
	// Mask and drop counter
	// ************************************************************

	always_ff @(posedge fifo_clk)
	begin
		if (!rst_n)
			chan_mask <= MASK_RESET;
		else if (do_set_mask)
			chan_mask <= arg;
	end

	always_ff @(posedge fifo_clk)
	begin
		if (!rst_n)
			drops <= '0;
		else if (do_clr_drops)
			drops <= '0;                        // Clear beats a drop in the same cycle
		else if (drop_pulse && !(&drops))
			drops <= drops + 1'b1;              // Sticks at all ones
	end

	// ************************************************************
	// Reply sequencer
	// ************************************************************

	always_ff @(posedge fifo_clk)
	begin
		if (!rst_n)
			reply_left <= '0;
		else if (do_get_mask)
			reply_left <= REPLY_LEN_MASK;
		else if (do_get_drops)
			reply_left <= REPLY_LEN_DROPS;
		else if (reply_ack && reply_rdy)
			reply_left <= reply_left - 1'b1;
	end

	// Reply bytes with the count snapshot taken at the command
	always_ff @(posedge fifo_clk)
	begin
		if (do_get_mask)
			reply <= fx2_byte_t'(chan_mask);    // Mask in the low nibble
		else if (do_get_drops)
		begin
			reply      <= drops[7:0];           // Low byte first
			reply_next <= drops[15:8];
		end
		else if (reply_ack)
			reply <= reply_next;
	end

	assign reply_rdy = (reply_left != '0);
	assign reply_end = (reply_left == reply_cnt_t'(1));

	// Last-byte marker only with a byte on offer
	a_end_has_rdy: assert property (@(posedge fifo_clk) disable iff (!rst_n)
		reply_end |-> reply_rdy);

	// Link acks only a byte that is on offer
	a_ack_has_rdy: assert property (@(posedge fifo_clk) disable iff (!rst_n)
		reply_ack |-> reply_rdy);

endmodule

/* hdl/fx2_bidir.sv */
`timescale 1ns/1ps

module fx2_bidir (
	input  logic                fifo_clk,
	input  logic                rst_n,
	// FX2 pins
	inout  wire fx2_pkg::fx2_byte_t fx2_fd,
	input  logic [2:0]          fx2_flags,     // Active low
	output logic                fx2_slrd,
	output logic                fx2_slwr,
	output logic                fx2_sloe,
	output logic                fx2_pktend,
	output logic                fx2_wu2,
	output fx2_pkg::fx2_addr_t  fx2_fifoadr,
	// Sample stream toward FIFO6
	input  tagger_pkg::sample_t sample,
	input  logic                sample_rdy,
	output logic                sample_ack,
	// Host bytes out of FIFO2
	output fx2_pkg::fx2_byte_t  cmd,
	output logic                cmd_wr,
	// Reply bytes toward FIFO8
	input  fx2_pkg::fx2_byte_t  reply,
	input  logic                reply_rdy,
	input  logic                reply_end,
	output logic                reply_ack
);
	import fx2_pkg::*;

	fx2_flags_t  flags;          // Flags in active-high form
	link_state_t state;
	link_state_t state_nxt;
	fx2_byte_t   bus_out;        // Byte headed for the FX2
	logic        sample_wr;      // FIFO6 write this cycle
	logic        reply_wr;       // FIFO8 write this cycle
	logic        fifo_wr;
	logic        fifo_rd;
	logic        fifo_oe;        // FX2 owns the bus
	logic        fifo_pktend;

	// ************************************************************
	// Pin polarity
	// ************************************************************

	assign flags      = fx2_flags_t'(~fx2_flags);
	assign fx2_wu2    = 1'b1;                 // Wakeup held inactive
	assign fx2_slrd   = ~fifo_rd;
	assign fx2_slwr   = ~fifo_wr;
	assign fx2_sloe   = ~fifo_oe;
	assign fx2_pktend = ~fifo_pktend;

	// ************************************************************
	// Link state machine
	// ************************************************************

	always_ff @(posedge fifo_clk)
	begin
		if (!rst_n)
			state <= LINK_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			LINK_IDLE:
			begin
				// Host first, then replies, then samples
				if (flags.cmd_avail)
					state_nxt = LINK_CMD_TURN;
				else if (reply_rdy && flags.reply_room)
					state_nxt = LINK_REPLY_TX;
				else if (sample_rdy && flags.sample_room)
					state_nxt = LINK_SAMPLE_TX;
			end
			LINK_SAMPLE_TX:
			begin
				if (flags.cmd_avail)
					state_nxt = LINK_CMD_TURN;      // Host preempts the stream
				else if (!flags.sample_room || !sample_rdy)
					state_nxt = LINK_IDLE;          // Also frees the link for a waiting reply
			end
			LINK_CMD_TURN:
				state_nxt = LINK_CMD_RX;
			LINK_CMD_RX:
			begin
				if (!flags.cmd_avail)
					state_nxt = LINK_IDLE;          // FIFO2 drained
			end
			LINK_REPLY_TX:
			begin
				if (reply_wr && reply_end)
					state_nxt = LINK_REPLY_END;     // Last byte went out
			end
			LINK_REPLY_END:
				state_nxt = LINK_REPLY_TURN;
			LINK_REPLY_TURN:
				state_nxt = LINK_IDLE;
			default:
				state_nxt = LINK_IDLE;
		endcase
	end

	// FIFOADR follows the state
	always_comb
	begin
		case (state)
			LINK_CMD_TURN, LINK_CMD_RX:
				fx2_fifoadr = FX2_ADDR_CMD;
			LINK_REPLY_TX, LINK_REPLY_END, LINK_REPLY_TURN:
				fx2_fifoadr = FX2_ADDR_REPLY;
			default:
				fx2_fifoadr = FX2_ADDR_SAMPLE;
		endcase
	end

	// ************************************************************
	// Strobes and data bus
	// ************************************************************

	// No sample write in the cycle the host shows up
	assign sample_wr = (state == LINK_SAMPLE_TX) && sample_rdy
		&& !flags.cmd_avail && flags.sample_room;
	assign reply_wr  = (state == LINK_REPLY_TX) && flags.reply_room;   // Holds on a full FIFO8

	assign fifo_wr     = sample_wr || reply_wr;
	assign fifo_oe     = (state == LINK_CMD_TURN) || (state == LINK_CMD_RX);
	assign fifo_rd     = (state == LINK_CMD_RX) && flags.cmd_avail;
	assign fifo_pktend = (state == LINK_REPLY_END);

	assign sample_ack = sample_wr;
	assign reply_ack  = reply_wr;
	assign cmd_wr     = fifo_rd;

	assign bus_out = (state == LINK_SAMPLE_TX) ? sample : reply;
	assign fx2_fd  = fifo_wr ? bus_out : 'z;        // Released unless writing
	assign cmd     = fifo_rd ? fx2_fd : '0;

	// Never read and write in one cycle
	a_strobe_excl: assert property (@(posedge fifo_clk) disable iff (!rst_n)
		!(!fx2_slrd && !fx2_slwr));

	// Bus stays released while SLOE is low and in the cycle before
	a_bus_turn: assert property (@(posedge fifo_clk) disable iff (!rst_n)
		!fx2_sloe |-> !fifo_wr && $past(!fifo_wr));

endmodule

/* hdl/fx2_pkg.sv */
package fx2_pkg;

	// ************************************************************
	// FX2 slave-FIFO bus types
	// ************************************************************

	typedef logic [7:0] fx2_byte_t;    // One word on the FD bus
	typedef logic [1:0] fx2_addr_t;    // FIFOADR pin code

	// FIFOADR codes for the three endpoints in use
	localparam fx2_addr_t FX2_ADDR_CMD    = 2'd0;   // Host commands arrive in FIFO2
	localparam fx2_addr_t FX2_ADDR_SAMPLE = 2'd2;   // Sample stream leaves through FIFO6
	localparam fx2_addr_t FX2_ADDR_REPLY  = 2'd3;   // Command replies leave through FIFO8

	// Flag pins after inversion to active high
	// Bit order matches the FLAGS pins
	typedef struct packed {
		logic reply_room;    // FIFO8 not full
		logic sample_room;   // FIFO6 not full
		logic cmd_avail;     // FIFO2 holds data
	} fx2_flags_t;

	// ************************************************************
	// Link arbiter states
	// ************************************************************

	typedef enum logic [2:0] {
		LINK_IDLE,         // Waiting for work
		LINK_SAMPLE_TX,    // Streaming samples into FIFO6
		LINK_CMD_TURN,     // Bus turnaround before reading FIFO2
		LINK_CMD_RX,       // Reading host bytes
		LINK_REPLY_TX,     // Writing reply bytes into FIFO8
		LINK_REPLY_END,    // Packet end strobe
		LINK_REPLY_TURN    // One quiet cycle after the packet
	} link_state_t;

endpackage

/* hdl/pulse_queue.sv */
`timescale 1ns/1ps

module pulse_queue #(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic                            fifo_clk,
	input  logic                            rst_n,
	input  logic [tagger_pkg::NUM_CHAN-1:0] pulse,        // Synchronous to fifo_clk
	input  tagger_pkg::chan_mask_t          chan_mask,
	input  logic                            sample_ack,   // Pop
	output tagger_pkg::sample_t             sample,       // Head of queue
	output logic                            sample_rdy,   // Queue not empty
	output logic                            drop_pulse
);
	import tagger_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	logic [NUM_CHAN-1:0] pulse_q;        // Previous pulse levels
	logic [NUM_CHAN-1:0] hits;           // Enabled rising edges
	stamp_t              stamp_cnt;
	sample_t             event_q;        // Event waiting for push
	logic                event_vld;
	sample_t             mem [QUEUE_DEPTH];
	ptr_t                wr_ptr;
	ptr_t                rd_ptr;
	cnt_t                fill;
	logic                full;
	logic                push;
	logic                pop;

	function automatic ptr_t next_ptr(input ptr_t p);
		if (p == ptr_t'(QUEUE_DEPTH - 1))
			return '0;                          // Wrap for any depth
		return p + 1'b1;
	endfunction

	// ************************************************************
	// Edge capture and time stamp
	// ************************************************************

	assign hits = pulse & ~pulse_q & chan_mask;

	always_ff @(posedge fifo_clk)
	begin
		if (!rst_n)
		begin
			pulse_q   <= '0;
			stamp_cnt <= '0;
			event_vld <= 1'b0;
		end
		else
		begin
			pulse_q   <= pulse;
			stamp_cnt <= stamp_cnt + 1'b1;      // Free running
			event_vld <= |hits;
		end
	end

	always_ff @(posedge fifo_clk)
	begin
		event_q.hits  <= hits;
		event_q.stamp <= stamp_cnt;             // Time of the sampling edge
	end

	// ************************************************************
	// Circular buffer with fall-through head
	// ************************************************************

	assign full       = (fill == cnt_t'(QUEUE_DEPTH));
	assign push       = event_vld && !full;       // Full at the push edge loses the event
	assign drop_pulse = event_vld && full;
	assign pop        = sample_ack && sample_rdy;
	assign sample_rdy = (fill != '0);
	assign sample     = mem[rd_ptr];

	always_ff @(posedge fifo_clk)
	begin
		if (push)
			mem[wr_ptr] <= event_q;
	end

	always_ff @(posedge fifo_clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				fill <= fill + 1'b1;
			else if (pop && !push)
				fill <= fill - 1'b1;
		end
	end

	// Link pops only a queue with data
	a_no_underflow: assert property (@(posedge fifo_clk) disable iff (!rst_n)
		sample_ack |-> sample_rdy);

	a_fill_bound: assert property (@(posedge fifo_clk) disable iff (!rst_n)
		fill <= cnt_t'(QUEUE_DEPTH));

endmodule

/* hdl/tagger_pkg.sv */
package tagger_pkg;

	// ************************************************************
	// Pulse sample format
	// ************************************************************

	localparam int NUM_CHAN = 4;           // Pulse inputs, fixed by the sample byte

	typedef logic [NUM_CHAN-1:0] chan_mask_t;    // One enable bit per channel
	typedef logic [3:0]          stamp_t;        // Free-running coarse time
	typedef logic [15:0]         drop_count_t;   // Saturates at all ones

	// One event per byte
	typedef struct packed {
		logic [NUM_CHAN-1:0] hits;    // Channels that fired
		stamp_t              stamp;   // Counter value at the edge
	} sample_t;

	// All channels live out of reset
	localparam chan_mask_t MASK_RESET = '1;

	// ************************************************************
	// Host command set
	// ************************************************************

	// Upper nibble of a command byte
	typedef logic [3:0] opcode_t;

	localparam opcode_t OP_SET_MASK  = 4'd1;   // Low nibble becomes the mask
	localparam opcode_t OP_GET_MASK  = 4'd2;   // Mask comes back in one byte
	localparam opcode_t OP_GET_DROPS = 4'd3;   // Drop count comes back low byte first
	localparam opcode_t OP_CLR_DROPS = 4'd4;   // Zero the drop count

	// Bytes left in a reply
	typedef logic [1:0] reply_cnt_t;

	localparam reply_cnt_t REPLY_LEN_MASK  = 2'd1;
	localparam reply_cnt_t REPLY_LEN_DROPS = 2'd2;

endpackage

/* hdl/tagger_top.sv */
`timescale 1ns/1ps

module tagger_top #(
	parameter int QUEUE_DEPTH = 16
) (
	input  logic                            fifo_clk,
	input  logic                            rst_n,
	input  logic [tagger_pkg::NUM_CHAN-1:0] pulse,
	// FX2 slave-FIFO pins
	inout  wire fx2_pkg::fx2_byte_t         fx2_fd,
	input  logic [2:0]                      fx2_flags,
	output logic                            fx2_slrd,
	output logic                            fx2_slwr,
	output logic                            fx2_sloe,
	output logic                            fx2_pktend,
	output logic                            fx2_wu2,
	output fx2_pkg::fx2_addr_t              fx2_fifoadr
);
	import fx2_pkg::*;
	import tagger_pkg::*;

	// Sample path
	sample_t    sample;
	logic       sample_rdy;
	logic       sample_ack;
	// Command and reply paths
	fx2_byte_t  cmd;
	logic       cmd_wr;
	fx2_byte_t  reply;
	logic       reply_rdy;
	logic       reply_end;
	logic       reply_ack;
	// Control between engine and queue
	chan_mask_t chan_mask;
	logic       drop_pulse;

	// ************************************************************
	// FX2 link, command engine, pulse queue
	// ************************************************************

	fx2_bidir u_link (
		.fifo_clk    (fifo_clk),
		.rst_n       (rst_n),
		.fx2_fd      (fx2_fd),
		.fx2_flags   (fx2_flags),
		.fx2_slrd    (fx2_slrd),
		.fx2_slwr    (fx2_slwr),
		.fx2_sloe    (fx2_sloe),
		.fx2_pktend  (fx2_pktend),
		.fx2_wu2     (fx2_wu2),
		.fx2_fifoadr (fx2_fifoadr),
		.sample      (sample),
		.sample_rdy  (sample_rdy),
		.sample_ack  (sample_ack),
		.cmd         (cmd),
		.cmd_wr      (cmd_wr),
		.reply       (reply),
		.reply_rdy   (reply_rdy),
		.reply_end   (reply_end),
		.reply_ack   (reply_ack)
	);

	cmd_engine u_cmd (
		.fifo_clk   (fifo_clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.cmd_wr     (cmd_wr),
		.drop_pulse (drop_pulse),
		.reply      (reply),
		.reply_rdy  (reply_rdy),
		.reply_end  (reply_end),
		.reply_ack  (reply_ack),
		.chan_mask  (chan_mask)
	);

	pulse_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.fifo_clk   (fifo_clk),
		.rst_n      (rst_n),
		.pulse      (pulse),
		.chan_mask  (chan_mask),
		.sample_ack (sample_ack),
		.sample     (sample),
		.sample_rdy (sample_rdy),
		.drop_pulse (drop_pulse)
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the time-tagger testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module tb_tagger_top \
	-Mdir obj_dir -o tb_sim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "SIMULATION PASSED" "$LOG" \
	&& { echo "Result: pass"; exit 0; } \
	|| { echo "Result: fail"; exit 1; }

/* tests/tb_tagger_top.sv */
`timescale 1ns/1ps

module tb_tagger_top;
	import fx2_pkg::*;
	import tagger_pkg::*;

	localparam int QUEUE_DEPTH = 16;
	localparam int WAIT_LIMIT  = 2000;     // Cycles per wait loop

	logic        fifo_clk = 1'b0;
	logic        rst_n;
	logic [3:0]  pulse;
	logic [2:0]  fx2_flags;                // Active low {FIFO8 full, FIFO6 full, FIFO2 empty}
	tri1  [7:0]  fx2_fd;                   // Released bus reads as all ones
	logic        fx2_slrd;
	logic        fx2_slwr;
	logic        fx2_sloe;
	logic        fx2_pktend;
	logic        fx2_wu2;
	fx2_addr_t   fx2_fifoadr;

	// ************************************************************
	// Host model and stimulus controls
	// ************************************************************

	logic [15:0] lfsr = 16'd35767;
	fx2_byte_t   cmd_q[$];                 // Bytes waiting in FIFO2
	fx2_byte_t   host_byte;                // Head of FIFO2 on the bus
	int          room6_mode;               // 0 withheld, 1 random, 2 always
	int          room8_mode;
	int          pulse_mode;               // 0 quiet, 1 sparse, 2 burst

	// Reference model state
	sample_t     exp_q[$];                 // Predicted queue contents
	fx2_byte_t   exp_reply[$];
	int          exp_len[$];               // Bytes per expected packet
	sample_t     pend_sample;              // Event captured with its push due next edge
	logic        pend_vld;
	logic [3:0]  pulse_prev;
	chan_mask_t  model_mask;
	drop_count_t model_drops;
	int          edge_cnt;                 // Edges since reset release
	int          pkt_bytes;
	int          n_samples;

	tagger_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) DUT (
		.fifo_clk    (fifo_clk),
		.rst_n       (rst_n),
		.pulse       (pulse),
		.fx2_fd      (fx2_fd),
		.fx2_flags   (fx2_flags),
		.fx2_slrd    (fx2_slrd),
		.fx2_slwr    (fx2_slwr),
		.fx2_sloe    (fx2_sloe),
		.fx2_pktend  (fx2_pktend),
		.fx2_wu2     (fx2_wu2),
		.fx2_fifoadr (fx2_fifoadr)
	);

	always #10 fifo_clk = ~fifo_clk;

	// FX2 drives FIFO2 data only while SLOE is low
	assign fx2_fd = !fx2_sloe ? host_byte : 8'hzz;

	// ************************************************************
	// Helpers
	// ************************************************************

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;        // Taps 16,14,13,11
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic room_flag(input int mode);
		if (mode == 0)
			return 1'b0;
		if (mode == 1)
			return rand_bits(2) != 8'd3;       // Full about one cycle in four
		return 1'b1;
	endfunction

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic next_cycle(input int n);
		repeat (n) @(posedge fifo_clk);
		#1;                                    // Clear of the edge
	endtask

	task automatic drain_samples();
		int t;
		for (t = 0; t < WAIT_LIMIT && (exp_q.size() != 0 || pend_vld); t++)
			next_cycle(1);
		assert (exp_q.size() == 0 && !pend_vld)
		else
		begin
			$display("Timeout: predicted samples never reached FIFO6");
			stop_run();
		end
	endtask

	// FIFO2 drained and every expected packet closed
	task automatic wait_host_done();
		int t;
		for (t = 0; t < WAIT_LIMIT && (cmd_q.size() != 0 || exp_len.size() != 0); t++)
			next_cycle(1);
		assert (cmd_q.size() == 0 && exp_len.size() == 0)
		else
		begin
			$display("Timeout: command not read or reply packet never ended");
			stop_run();
		end
	endtask

	// ************************************************************
	// Drive side on the falling edge
	// ************************************************************

	always @(negedge fifo_clk)
	begin
		logic [3:0] p;
		host_byte    <= (cmd_q.size() != 0) ? cmd_q[0] : 8'h00;
		fx2_flags[0] <= (cmd_q.size() == 0);   // Empty flag
		fx2_flags[1] <= !room_flag(room6_mode);
		fx2_flags[2] <= !room_flag(room8_mode);
		p = '0;
		if (pulse_mode == 1)
		begin
			for (int i = 0; i < 4; i++)
				p[i] = (rand_bits(4) == 8'hF);  // Rare one-cycle pulses
		end
		else if (pulse_mode == 2)
			p = (pulse == 4'hF) ? 4'h0 : 4'hF; // Edge every other cycle
		pulse <= p;
	end

	// ************************************************************
	// Monitor and reference model on the rising edge
	// ************************************************************

	always @(posedge fifo_clk)
	begin
		logic        full_now;
		logic        clr_now;
		logic [3:0]  hits;
		chan_mask_t  new_mask;
		drop_count_t old_drops;
		fx2_byte_t   op;
		if (!rst_n)
		begin
			exp_q.delete();
			exp_reply.delete();
			exp_len.delete();
			pend_vld    = 1'b0;
			pend_sample = '0;
			pulse_prev  = '0;
			model_mask  = 4'hF;
			model_drops = '0;
			edge_cnt    = 0;
			pkt_bytes   = 0;
			n_samples   = 0;
		end
		else
		begin
			full_now  = (exp_q.size() == QUEUE_DEPTH);   // Before this edge's pop
			clr_now   = 1'b0;
			new_mask  = model_mask;
			old_drops = model_drops;
			assert (fx2_slwr || fx2_fifoadr == FX2_ADDR_SAMPLE
				|| fx2_fifoadr == FX2_ADDR_REPLY)
			else
			begin
				$display("Write strobe at FIFO address %0d", fx2_fifoadr);
				stop_run();
			end
			if (!fx2_slwr && fx2_fifoadr == FX2_ADDR_SAMPLE)
			begin
				assert (exp_q.size() != 0)
				else
				begin
					$display("FIFO6 write with no sample predicted");
					stop_run();
				end
				check_value("fx2_fd at FIFO6", fx2_fd, exp_q[0]);
				void'(exp_q.pop_front());
				n_samples++;
			end
			else if (!fx2_slwr && fx2_fifoadr == FX2_ADDR_REPLY)
			begin
				assert (exp_reply.size() != 0)
				else
				begin
					$display("FIFO8 write with no reply byte expected");
					stop_run();
				end
				check_value("fx2_fd at FIFO8", fx2_fd, exp_reply.pop_front());
				pkt_bytes++;
			end
			if (!fx2_pktend)
			begin
				assert (fx2_fifoadr == FX2_ADDR_REPLY && exp_len.size() != 0)
				else
				begin
					$display("Packet end with no reply packet open");
					stop_run();
				end
				check_value("bytes before fx2_pktend", pkt_bytes, exp_len.pop_front());
				pkt_bytes = 0;
			end
			// Event seen one edge ago is pushed now, or lost when full
			if (pend_vld && full_now)
				model_drops = (model_drops == '1) ? model_drops : model_drops + 1'b1;
			else if (pend_vld)
				exp_q.push_back(pend_sample);
			hits        = pulse & ~pulse_prev & model_mask;
			pend_sample = {hits, 4'(edge_cnt)};
			pend_vld    = |hits;
			pulse_prev  = pulse;
			edge_cnt++;
			if (!fx2_slrd)
			begin
				assert (cmd_q.size() != 0)
				else
				begin
					$display("FIFO2 read while the host had no data");
					stop_run();
				end
				op = cmd_q.pop_front();
				case (opcode_t'(op[7:4]))
					OP_SET_MASK:  new_mask = op[3:0];
					OP_CLR_DROPS: clr_now  = 1'b1;
					OP_GET_MASK:
					begin
						if (exp_reply.size() == 0)     // Ignored while a reply waits
						begin
							exp_reply.push_back({4'h0, model_mask});
							exp_len.push_back(1);
						end
					end
					OP_GET_DROPS:
					begin
						if (exp_reply.size() == 0)
						begin
							exp_reply.push_back(old_drops[7:0]);
							exp_reply.push_back(old_drops[15:8]);
							exp_len.push_back(2);
						end
					end
					default: ;
				endcase
			end
			if (clr_now)
				model_drops = '0;               // Clear wins over a drop
			model_mask = new_mask;
		end
	end

	// ************************************************************
	// Test sequence
	// ************************************************************

	initial
	begin
		chan_mask_t mask;
		rst_n      = 1'b0;
		pulse      = '0;
		fx2_flags  = 3'b111;                   // No data, no room
		host_byte  = '0;
		room6_mode = 0;
		room8_mode = 0;
		pulse_mode = 0;
		repeat (2) @(negedge fifo_clk);
		rst_n <= 1'b1;
		next_cycle(3);

		// Quiet bus after reset
		check_value("fx2_slrd", fx2_slrd, 1);
		check_value("fx2_slwr", fx2_slwr, 1);
		check_value("fx2_sloe", fx2_sloe, 1);
		check_value("fx2_pktend", fx2_pktend, 1);
		check_value("fx2_wu2", fx2_wu2, 1);
		check_value("fx2_fd", fx2_fd, 8'hFF);

		// Sparse stream with random FIFO6 room
		room6_mode = 1;
		pulse_mode = 1;
		next_cycle(300);
		pulse_mode = 0;
		drain_samples();
		check_value("drop count during sparse stream", model_drops, 0);

		// Mask write and readback, then masked pulses
		mask = chan_mask_t'(rand_bits(4));
		if (mask == 4'hF)
			mask = 4'b0110;                    // Keep some channels off
		room8_mode = 1;
		cmd_q.push_back({OP_SET_MASK, mask});
		cmd_q.push_back({OP_GET_MASK, 4'h0});
		wait_host_done();
		pulse_mode = 1;
		next_cycle(200);
		pulse_mode = 0;
		drain_samples();

		// Burst into a blocked FIFO6 overflows the queue
		room6_mode = 0;
		cmd_q.push_back({OP_SET_MASK, 4'hF});
		wait_host_done();
		pulse_mode = 2;
		next_cycle(2 * QUEUE_DEPTH + 12);
		pulse_mode = 0;
		next_cycle(4);
		assert (model_drops != 0)
		else
		begin
			$display("Burst did not overflow the queue");
			stop_run();
		end
		n_samples  = 0;
		room6_mode = 2;
		drain_samples();
		check_value("FIFO6 bytes after burst", n_samples, QUEUE_DEPTH);
		cmd_q.push_back({OP_GET_DROPS, 4'h0});
		wait_host_done();

		// Cleared counter reads back zero
		cmd_q.push_back({OP_CLR_DROPS, 4'h0});
		cmd_q.push_back({OP_GET_DROPS, 4'h0});
		wait_host_done();

		// Command during a busy sample stream
		pulse_mode = 1;
		next_cycle(40);
		cmd_q.push_back({OP_GET_MASK, 4'h0});
		wait_host_done();
		next_cycle(40);
		pulse_mode = 0;
		drain_samples();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
